/* design/cachePkg.sv */
package cachePkg;

	// ----------------------------------------------------------
	// geometry
	// ----------------------------------------------------------
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int lineWords = 4;
	localparam int offsetBits = $clog2(lineWords * wordWidth / 8); // byte offset in a line
	localparam int wordSelBits = $clog2(lineWords);

	typedef logic [addrWidth-1:0] addrT;
	typedef logic [wordWidth-1:0] wordT;
	typedef logic [lineWords*wordWidth-1:0] lineT; // word 0 in the low bits
	typedef logic [addrWidth-offsetBits-1:0] lineAddrT;

	// ----------------------------------------------------------
	// cpu and memory side bundles
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		opNone,
		opRead,
		opWrite,
		opInvalidate
	} cacheOpT;

	typedef struct packed {
		cacheOpT op;
		addrT addr;
		wordT wdata;
	} cpuReqT;

	typedef struct packed {
		logic hit;
		wordT rdata; // zero unless read
	} cpuRespT;

	// one whole line in either direction
	typedef struct packed {
		logic write;
		lineAddrT lineAddr;
		lineT line;
	} memReqT;

endpackage

/* design/tagStore.sv */
`timescale 1ns/1ps

module tagStore #(
	parameter int numSets = 16,
	localparam int indexBits = $clog2(numSets),
	localparam int tagBits = cachePkg::addrWidth - cachePkg::offsetBits - indexBits
) (
	input logic clk,
	input logic reset,
	input logic [indexBits-1:0] setIndex,
	input logic [tagBits-1:0] reqTag,
	input logic accessWay,
	input logic touch,
	input logic install,
	input logic markDirty,
	input logic invalidateWay,
	output logic hitValid,
	output logic hitWay,
	output logic victimWay,
	output logic victimDirty,
	output logic [tagBits-1:0] victimTag
);

	logic [tagBits-1:0] tags [2][numSets];
	logic [1:0][numSets-1:0] valid;
	logic [1:0][numSets-1:0] dirty;
	logic [numSets-1:0] lru; // way to evict next
	logic [1:0] wayHit;

	// ----------------------------------------------------------
	// lookup
	// ----------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = valid[w][setIndex] && (tags[w][setIndex] == reqTag);
		end
	end

	assign hitValid = |wayHit;
	assign hitWay = wayHit[1];

	always_comb begin
		if (!valid[0][setIndex]) begin
			victimWay = 1'b0; // empty way first
		end else if (!valid[1][setIndex]) begin
			victimWay = 1'b1;
		end else begin
			victimWay = lru[setIndex];
		end
	end

	// state of the line the controller is working on
	assign victimDirty = valid[accessWay][setIndex] && dirty[accessWay][setIndex];
	assign victimTag = tags[accessWay][setIndex];

	// ----------------------------------------------------------
	// updates
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			if (install) begin
				valid[accessWay][setIndex] <= 1'b1;
				dirty[accessWay][setIndex] <= markDirty; // write miss lands dirty
			end else if (markDirty) begin
				dirty[accessWay][setIndex] <= 1'b1;
			end
			if (invalidateWay) begin
				valid[accessWay][setIndex] <= 1'b0;
				dirty[accessWay][setIndex] <= 1'b0;
			end
			if (touch || install) begin
				lru[setIndex] <= ~accessWay;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (install) begin
			tags[accessWay][setIndex] <= reqTag;
		end
	end

endmodule

/* design/dataStore.sv */
`timescale 1ns/1ps

module dataStore #(
	parameter int numSets = 16,
	localparam int indexBits = $clog2(numSets)
) (
	input logic clk,
	input logic [indexBits-1:0] setIndex,
	input logic accessWay,
	input logic [cachePkg::wordSelBits-1:0] wordSel,
	input logic wordWrite,
	input cachePkg::wordT writeWord,
	input logic lineFill,
	input cachePkg::lineT fillLine,
	output cachePkg::wordT readWord,
	output cachePkg::lineT readLine
);
	import cachePkg::*;

	wordT lines [2][numSets][lineWords];

	// ----------------------------------------------------------
	// writes
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (lineFill) begin
			for (int w = 0; w < lineWords; w++) begin
				lines[accessWay][setIndex][w] <= fillLine[w*wordWidth +: wordWidth];
			end
		end
		// a word write lands on top of a fill in the same edge
		if (wordWrite) begin
			lines[accessWay][setIndex][wordSel] <= writeWord;
		end
	end

	// reads
	assign readWord = lines[accessWay][setIndex][wordSel];

	always_comb begin
		for (int w = 0; w < lineWords; w++) begin
			readLine[w*wordWidth +: wordWidth] = lines[accessWay][setIndex][w];
		end
	end

endmodule

/* design/memoryPort.sv */
`timescale 1ns/1ps

module memoryPort (
	input logic clk,
	input logic reset,
	input logic memPortStart,
	input cachePkg::memReqT memPortReq,
	output logic memPortDone,
	output cachePkg::lineT fillLine,
	output cachePkg::memReqT memReq,
	output logic memReqValid,
	input logic memAck,
	input cachePkg::lineT memRdata
);

	logic accepted;

	assign accepted = memReqValid && memAck;

	// ----------------------------------------------------------
	// request level held until memory acknowledges
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			memReqValid <= 1'b0;
			memPortDone <= 1'b0;
		end else begin
			memPortDone <= accepted; // one cycle after the ack
			if (memPortStart) begin
				memReqValid <= 1'b1;
			end else if (accepted) begin
				memReqValid <= 1'b0;
			end
		end
	end

	// request and returned line
	always_ff @(posedge clk) begin
		if (memPortStart) begin
			memReq <= memPortReq;
		end
		if (accepted && !memReq.write) begin
			fillLine <= memRdata;
		end
	end

endmodule

/* design/cacheController.sv */
`timescale 1ns/1ps

module cacheController #(
	parameter int numSets = 16,
	localparam int indexBits = $clog2(numSets),
	localparam int tagBits = cachePkg::addrWidth - cachePkg::offsetBits - indexBits
) (
	input logic clk,
	input logic reset,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRespT cpuResp,
	output logic done,
	input logic hitValid,
	input logic hitWay,
	input logic victimWay,
	input logic victimDirty,
	input logic [tagBits-1:0] victimTag,
	output logic [indexBits-1:0] setIndex,
	output logic [tagBits-1:0] reqTag,
	output logic touch,
	output logic install,
	output logic markDirty,
	output logic invalidateWay,
	output logic accessWay,
	output logic [cachePkg::wordSelBits-1:0] wordSel,
	output logic wordWrite,
	output logic lineFill,
	output cachePkg::wordT writeWord,
	input cachePkg::wordT readWord,
	input cachePkg::lineT readLine,
	output logic memPortStart,
	output cachePkg::memReqT memPortReq,
	input logic memPortDone,
	input cachePkg::lineT fillLine
);
	import cachePkg::*;

	typedef enum logic [2:0] {
		idle,
		compare,
		writeBack,
		refill,
		respond
	} ctrlStateT;

	ctrlStateT state;
	ctrlStateT nextState;
	logic wayReg; // way picked at compare
	logic respHit;
	wordT respData;
	logic isRead;
	logic isWrite;
	logic isAccess;
	logic isInval;
	logic wbNeeded;
	lineAddrT reqLineAddr;

	// ----------------------------------------------------------
	// address split
	// ----------------------------------------------------------
	// the cpu holds the request until done
	assign isRead = cpuReq.op == opRead;
	assign isWrite = cpuReq.op == opWrite;
	assign isAccess = isRead || isWrite;
	assign isInval = cpuReq.op == opInvalidate;

	assign setIndex = cpuReq.addr[offsetBits +: indexBits];
	assign reqTag = cpuReq.addr[addrWidth-1 -: tagBits];
	assign wordSel = cpuReq.addr[offsetBits-1 -: wordSelBits];
	assign reqLineAddr = cpuReq.addr[addrWidth-1:offsetBits];
	assign writeWord = cpuReq.wdata;

	// hit way on a hit, lru victim otherwise
	assign accessWay = (state == compare) ? (hitValid ? hitWay : victimWay) : wayReg;

	assign done = state == respond;
	assign cpuResp.hit = respHit;
	assign cpuResp.rdata = respData;

	// victimDirty follows accessWay and so covers eviction and invalidate
	assign wbNeeded = (state == compare) && victimDirty;

	always_comb begin
		memPortReq.write = wbNeeded;
		memPortReq.lineAddr = wbNeeded ? {victimTag, setIndex} : reqLineAddr;
		memPortReq.line = readLine;
	end

	// ----------------------------------------------------------
	// state machine
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		touch = 1'b0;
		install = 1'b0;
		markDirty = 1'b0;
		invalidateWay = 1'b0;
		wordWrite = 1'b0;
		lineFill = 1'b0;
		memPortStart = 1'b0;
		case (state)
			idle: begin
				if (cpuReq.op != opNone) begin
					nextState = compare;
				end
			end
			compare: begin
				if (isAccess && hitValid) begin
					touch = 1'b1;
					wordWrite = isWrite;
					markDirty = isWrite;
					nextState = respond;
				end else if (isAccess) begin
					memPortStart = 1'b1; // writeback or refill request
					nextState = victimDirty ? writeBack : refill;
				end else if (isInval && hitValid && victimDirty) begin
					memPortStart = 1'b1;
					nextState = writeBack;
				end else begin
					invalidateWay = isInval && hitValid; // clean or absent
					nextState = respond;
				end
			end
			writeBack: begin
				if (memPortDone) begin
					if (isInval) begin
						invalidateWay = 1'b1;
						nextState = respond;
					end else begin
						memPortStart = 1'b1; // now fetch the requested line
						nextState = refill;
					end
				end
			end
			refill: begin
				if (memPortDone) begin
					// fill, install and the word access share one edge
					lineFill = 1'b1;
					install = 1'b1;
					wordWrite = isWrite;
					markDirty = isWrite;
					nextState = respond;
				end
			end
			respond: nextState = idle;
			default: nextState = idle;
		endcase
	end

	// response payload
	always_ff @(posedge clk) begin
		if (state == compare) begin
			wayReg <= accessWay;
			respHit <= hitValid;
			respData <= (isRead && hitValid) ? readWord : '0;
		end
		if (state == refill && memPortDone && isRead) begin
			respData <= fillLine[wordSel*wordWidth +: wordWidth];
		end
	end

endmodule

/* design/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop #(
	parameter int numSets = 16,
	localparam int indexBits = $clog2(numSets),
	localparam int tagBits = cachePkg::addrWidth - cachePkg::offsetBits - indexBits
) (
	input logic clk,
	input logic reset,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRespT cpuResp,
	output logic done,
	output cachePkg::memReqT memReq,
	output logic memReqValid,
	input logic memAck,
	input cachePkg::lineT memRdata
);
	import cachePkg::*;

	// lookup
	logic [indexBits-1:0] setIndex;
	logic [tagBits-1:0] reqTag;
	logic hitValid;
	logic hitWay;
	logic victimWay;
	logic victimDirty;
	logic [tagBits-1:0] victimTag;

	// tag updates
	logic touch;
	logic install;
	logic markDirty;
	logic invalidateWay;
	logic accessWay;

	// data path
	logic [wordSelBits-1:0] wordSel;
	logic wordWrite;
	logic lineFill;
	wordT writeWord;
	wordT readWord;
	lineT readLine;

	// memory port
	logic memPortStart;
	memReqT memPortReq;
	logic memPortDone;
	lineT fillLine;

	cacheController #(.numSets(numSets)) controller (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp),
		.done(done),
		.hitValid(hitValid),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.setIndex(setIndex),
		.reqTag(reqTag),
		.touch(touch),
		.install(install),
		.markDirty(markDirty),
		.invalidateWay(invalidateWay),
		.accessWay(accessWay),
		.wordSel(wordSel),
		.wordWrite(wordWrite),
		.lineFill(lineFill),
		.writeWord(writeWord),
		.readWord(readWord),
		.readLine(readLine),
		.memPortStart(memPortStart),
		.memPortReq(memPortReq),
		.memPortDone(memPortDone),
		.fillLine(fillLine)
	);

	tagStore #(.numSets(numSets)) tags (
		.clk(clk),
		.reset(reset),
		.setIndex(setIndex),
		.reqTag(reqTag),
		.accessWay(accessWay),
		.touch(touch),
		.install(install),
		.markDirty(markDirty),
		.invalidateWay(invalidateWay),
		.hitValid(hitValid),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimTag(victimTag)
	);

	dataStore #(.numSets(numSets)) data (
		.clk(clk),
		.setIndex(setIndex),
		.accessWay(accessWay),
		.wordSel(wordSel),
		.wordWrite(wordWrite),
		.writeWord(writeWord),
		.lineFill(lineFill),
		.fillLine(fillLine),
		.readWord(readWord),
		.readLine(readLine)
	);

	memoryPort memPort (
		.clk(clk),
		.reset(reset),
		.memPortStart(memPortStart),
		.memPortReq(memPortReq),
		.memPortDone(memPortDone),
		.fillLine(fillLine),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.memAck(memAck),
		.memRdata(memRdata)
	);

endmodule

/* verification/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb;
	import cachePkg::*;

	localparam int numSets = 16;
	localparam int numRecords = 26;
	localparam int fieldsPerRecord = 7;
	localparam int cycleLimit = numRecords * 40 + 20;

	logic clk;
	logic reset;
	cpuReqT cpuReq;
	cpuRespT cpuResp;
	logic done;
	memReqT memReq;
	logic memReqValid;
	logic memAck;
	lineT memRdata;

	logic [31:0] golden [numRecords*fieldsPerRecord];
	wordT memWords [addrT]; // keyed by word address
	lineAddrT wbQueue [$];
	integer seed = 13;
	int cycleCount = 0;

	cacheTop #(.numSets(numSets)) UUT (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp),
		.done(done),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.memAck(memAck),
		.memRdata(memRdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: no done from the cache after %0d cycles", cycleCount);
			stopOnFailure();
		end
	end

	// ------------------------------------------------------------
	// failure and compare tasks
	// ------------------------------------------------------------
	task automatic stopOnFailure();
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED time %0t %s expected %h actual %h",
				$time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkHit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED time %0t %s expected %b actual %b",
				$time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkLineAddr(input string name, input lineAddrT expected,
			input lineAddrT actual);
		if (actual !== expected) begin
			$display("CHECK FAILED time %0t %s expected %h actual %h",
				$time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	// ------------------------------------------------------------
	// memory model
	// ------------------------------------------------------------
	function automatic lineT readModelLine(input lineAddrT lineAddr);
		lineT line;
		addrT wordAddr;
		for (int i = 0; i < lineWords; i++) begin
			wordAddr = {2'b00, lineAddr, wordSelBits'(i)};
			if (memWords.exists(wordAddr)) begin
				line[i*wordWidth +: wordWidth] = memWords[wordAddr];
			end else begin
				line[i*wordWidth +: wordWidth] = wordAddr ^ 32'hA5A50000; // untouched pattern
			end
		end
		return line;
	endfunction

	task automatic storeModelLine(input lineAddrT lineAddr, input lineT line);
		addrT wordAddr;
		for (int i = 0; i < lineWords; i++) begin
			wordAddr = {2'b00, lineAddr, wordSelBits'(i)};
			memWords[wordAddr] = line[i*wordWidth +: wordWidth];
		end
	endtask

	initial begin : memoryModel
		int waitCycles;
		memAck = 1'b0;
		memRdata = '0;
		forever begin
			@(posedge clk);
			#1;
			memAck = 1'b0;
			if (memReqValid === 1'b1) begin
				waitCycles = 1 + ($unsigned($random(seed)) % 4);
				repeat (waitCycles) @(posedge clk);
				#1;
				if (memReq.write) begin
					storeModelLine(memReq.lineAddr, memReq.line);
					wbQueue.push_back(memReq.lineAddr);
				end else begin
					memRdata = readModelLine(memReq.lineAddr);
				end
				memAck = 1'b1; // one cycle pulse
			end
		end
	end

	// ------------------------------------------------------------
	// golden records
	// ------------------------------------------------------------
	task automatic runRecord(input int r);
		int base;
		cpuReqT req;
		logic expHit;
		wordT expData;
		logic expWb;
		lineAddrT expWbAddr;
		base = r * fieldsPerRecord;
		req.op = cacheOpT'(golden[base][1:0]);
		req.addr = golden[base+1];
		req.wdata = golden[base+2];
		expHit = golden[base+3][0];
		expData = golden[base+4];
		expWb = golden[base+5][0];
		expWbAddr = lineAddrT'(golden[base+6]);

		cpuReq = req;
		do begin
			@(negedge clk);
		end while (done !== 1'b1);

		checkHit("cpuResp.hit", expHit, cpuResp.hit);
		checkWord("cpuResp.rdata", expData, cpuResp.rdata);
		if (expWb) begin
			if (wbQueue.size() == 0) begin
				$display("record %0d: a writeback was expected but memory saw none", r);
				stopOnFailure();
			end else begin
				checkLineAddr("memReq.lineAddr", expWbAddr, wbQueue.pop_front());
			end
		end
		if (wbQueue.size() != 0) begin
			$display("record %0d: memory saw a writeback that was not expected", r);
			stopOnFailure();
		end

		@(posedge clk);
		#1; // next drive point
	endtask

	initial begin
		reset = 1'b1;
		cpuReq = '0;
		$readmemh("verification/cacheGolden.txt", golden);
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 0; r < numRecords; r++) begin
			runRecord(r);
		end
		cpuReq = '0;
		repeat (2) @(posedge clk);

		$display("sim passed");
		$finish;
	end

endmodule

/* verification/cacheGolden.txt */
// op addr wdata expHit expRdata wbFlag wbLineAddr, one record per line
// op 1 read, 2 write, 3 invalidate; untouched words read as (addr>>2)^a5a50000
1 00001010 00000000 0 a5a50404 0 00000000
1 00001010 00000000 1 a5a50404 0 00000000
2 00001014 deadbeef 1 00000000 0 00000000
1 00001014 00000000 1 deadbeef 0 00000000
1 00002010 00000000 0 a5a50804 0 00000000
1 00003010 00000000 0 a5a50c04 1 00000101
1 00001014 00000000 0 deadbeef 0 00000000
1 00001018 00000000 1 a5a50406 0 00000000
2 00004028 12345678 0 00000000 0 00000000
1 00004028 00000000 1 12345678 0 00000000
1 00004020 00000000 1 a5a51008 0 00000000
3 00004020 00000000 1 00000000 1 00000402
1 00004028 00000000 0 12345678 0 00000000
3 00004028 00000000 1 00000000 0 00000000
3 00005030 00000000 0 00000000 0 00000000
1 00004024 00000000 0 a5a51009 0 00000000
2 0000301c cafef00d 1 00000000 0 00000000
3 00003010 00000000 1 00000000 1 00000301
1 0000301c 00000000 0 cafef00d 0 00000000
1 00001014 00000000 1 deadbeef 0 00000000
3 00002010 00000000 0 00000000 0 00000000
1 00002010 00000000 0 a5a50804 0 00000000
2 00002014 0badcafe 1 00000000 0 00000000
1 00005010 00000000 0 a5a51404 0 00000000
1 00006010 00000000 0 a5a51804 1 00000201
1 00002014 00000000 0 0badcafe 0 00000000

/* sim.f */
design/cachePkg.sv
design/tagStore.sv
design/dataStore.sv
design/memoryPort.sv
design/cacheController.sv
design/cacheTop.sv
verification/cacheTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = cacheTb
FILELIST = sim.f
OBJDIR = obj_dir
PASSMSG = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
